/* predecode.f */
+incdir+src
+incdir+verification
src/predecodePkg.sv
src/instrClassifier.sv
src/boundaryScan.sv
src/laneSelect.sv
src/predecodeTop.sv
verification/predecodeTb.sv

/* src/boundaryScan.sv */
// Finds instruction starts in a bundle from the end markers and the
// start offset, and gives the length of the instruction at each parcel.
// Purely combinational.

`timescale 1ns/1ps

`include "predecode_config.svh"

module boundaryScan import predecodePkg::*; (
  input  logic [`PD_PARCELS-1:0] ends,
  input  offT                    startOff,
  output logic [`PD_PARCELS-1:0] startMask,
  output lenT [`PD_PARCELS-1:0]  lens,
  output logic                   badOff
);

  // end bits past the last start parcel read as clear
  logic [`PD_PARCELS+1:0] endsExt;

  assign endsExt = {2'b00, ends};

  // parcel 0 always begins a fresh instruction
  always_comb begin
    for (int k = 0; k < `PD_PARCELS; k++) begin
      if (offT'(k) < startOff)
        startMask[k] = 1'b0;
      else if (k == 0)
        startMask[k] = 1'b1;
      else
        startMask[k] = endsExt[k-1];
    end
  end

  // length runs to the first end marker and stops at four parcels
  always_comb begin
    for (int k = 0; k < `PD_PARCELS; k++) begin
      if (endsExt[k])
        lens[k] = 2'd0;
      else if (endsExt[k+1])
        lens[k] = 2'd1;
      else if (endsExt[k+2])
        lens[k] = 2'd2;
      else
        lens[k] = 2'd3;
    end
  end

  assign badOff = startOff >= offT'(`PD_PARCELS);

endmodule

/* src/instrClassifier.sv */
// Classifies one instruction into execution class flags.
// Uses the low byte as main opcode for multi-parcel encodings and the
// low six bits as sub-opcode for one-parcel encodings.

`timescale 1ns/1ps

module instrClassifier import predecodePkg::*; (
  input  logic [31:0] instr,
  input  lenT         len,
  output instClassT   cls
);

  logic [7:0] opMain;
  logic [5:0] opSub;
  logic [2:0] op182; // call/return selector for opcode 182

  assign opMain = instr[7:0];
  assign opSub  = instr[5:0];
  assign op182  = instr[15:13];

  always_comb begin
    cls = '0;
    if (len != 2'd0) begin
      case (opMain) inside
        [8'd0:8'd39]: begin
          if (opMain[2])
            cls.mul = 1'b1;
          else if (opMain inside {[8'd32:8'd35]})
            cls.shift = 1'b1;
          else
            cls.alu = 1'b1;
        end
        [8'd40:8'd45]: cls.shift = 1'b1;
        [8'd64:8'd159]: begin
          // even loads, odd stores
          cls.load  = ~opMain[0];
          cls.store = opMain[0];
        end
        [8'd160:8'd175], 8'd178, 8'd179: begin
          cls.jump = 1'b1; // conditional, compare in the ALU
          cls.alu  = 1'b1;
        end
        8'd180, 8'd181: cls.jump = 1'b1;
        8'd182: begin
          case (op182)
            3'd0, 3'd3: begin // indirect jump, return
              cls.jump  = 1'b1;
              cls.indir = 1'b1;
            end
            3'd1, 3'd2: begin // call pushes the link
              cls.jump  = 1'b1;
              cls.store = 1'b1;
            end
            default: ;
          endcase
        end
        default: ;
      endcase
    end else begin
      // compact encodings
      case (opSub) inside
        [6'd0:6'd19]: cls.alu = 1'b1;
        6'd21, 6'd23, 6'd25, 6'd27, 6'd29, 6'd31: cls.shift = 1'b1;
        [6'd48:6'd51]: cls.jump = 1'b1;
        default: ;
      endcase
    end
  end

endmodule

/* src/laneSelect.sv */
// Compacts the selected payloads, lowest index first, into a fixed set of
// lanes. Enables come out as a thermometer code, unused lanes carry zero.
// One instance per payload type.

`timescale 1ns/1ps

module laneSelect #(
  parameter type payloadT = logic [7:0],
  parameter int  NUM_IN    = 16,
  parameter int  NUM_LANES = 8
) (
  input  logic [NUM_IN-1:0]    sel,
  input  payloadT              payloads [NUM_IN],
  output payloadT              lanes [NUM_LANES],
  output logic [NUM_LANES-1:0] laneEn,
  output logic                 overflow
);

  localparam int CW = $clog2(NUM_IN + 1);

  logic [CW-1:0] prefix [NUM_IN]; // selected bits below each input
  logic [CW-1:0] total;

  always_comb begin
    logic [CW-1:0] run;
    run = '0;
    for (int k = 0; k < NUM_IN; k++) begin
      prefix[k] = run;
      run = run + CW'(sel[k]);
    end
    total = run;
  end

  // lane l takes the input whose prefix count is l
  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      lanes[l] = '0;
      for (int k = 0; k < NUM_IN; k++) begin
        if (sel[k] && prefix[k] == CW'(l))
          lanes[l] = payloads[k];
      end
      laneEn[l] = total > CW'(l);
    end
  end

  assign overflow = total > CW'(NUM_LANES);

endmodule

/* src/predecodePkg.sv */
// Shared types for the predecoder: class flags, lengths, parcel offsets
// and the slot payloads carried through the lane selectors.

`include "predecode_config.svh"

package predecodePkg;

  // execution class flags
  typedef struct packed {
    logic jump;
    logic indir;
    logic alu;
    logic shift;
    logic mul;
    logic load;
    logic store;
  } instClassT;

  // parcels minus one
  typedef logic [1:0] lenT;

  typedef logic [4:0] offT;

  // one decoded instruction
  typedef struct packed {
    logic [`PD_WINDOW_BITS-1:0] window; // text from the start parcel on
    lenT                        len;
    instClassT                  cls;
    offT                        off;
  } instSlotT;

  // jump lane payload, only the first two parcels of text
  typedef struct packed {
    instClassT   cls;
    offT         off;
    logic [31:0] text;
  } jumpSlotT;

endpackage

/* src/predecodeTop.sv */
// Registered instruction predecoder. Takes a fetch bundle, end markers
// and a start offset each cycle and presents packed instruction and jump
// lanes one cycle later. No handshake, outputs must be taken every cycle.

`timescale 1ns/1ps

`include "predecode_config.svh"

module predecodeTop import predecodePkg::*; (
  input  logic                                         clk,
  input  logic                                         arstN,
  input  logic [(`PD_PARCELS+`PD_TAIL)*`PD_PARCEL_BITS-1:0] bundle,
  input  logic [`PD_PARCELS-1:0]                       ends,
  input  offT                                          startOff,
  output instSlotT [`PD_LANES-1:0]                     slots,
  output logic [`PD_LANES-1:0]                         instrEn,
  output jumpSlotT [`PD_JLANES-1:0]                    jumps,
  output logic [`PD_JLANES-1:0]                        jumpEn,
  output logic                                         hasJumps,
  output logic                                         error,
  output logic                                         jerror
);

  logic [`PD_PARCELS-1:0]     startMask;
  lenT [`PD_PARCELS-1:0]      lens;
  logic                       badOff;
  logic [`PD_WINDOW_BITS-1:0] window [`PD_PARCELS];
  instClassT                  parcelCls [`PD_PARCELS];
  instSlotT                   instSlots [`PD_PARCELS];
  jumpSlotT                   jumpSlots [`PD_PARCELS];
  logic [`PD_PARCELS-1:0]     jumpSel;

  instSlotT                   laneSlots [`PD_LANES];
  logic [`PD_LANES-1:0]       laneInstEn;
  logic                       instOverflow;
  jumpSlotT                   laneJumps [`PD_JLANES];
  logic [`PD_JLANES-1:0]      laneJumpEn;
  logic                       jumpOverflow;

  boundaryScan uScan (
    .ends      (ends),
    .startOff  (startOff),
    .startMask (startMask),
    .lens      (lens),
    .badOff    (badOff)
  );

  for (genvar k = 0; k < `PD_PARCELS; k++) begin : gParcel
    assign window[k] = bundle[k*`PD_PARCEL_BITS +: `PD_WINDOW_BITS];

    instrClassifier uCls (
      .instr (window[k][31:0]),
      .len   (lens[k]),
      .cls   (parcelCls[k])
    );

    assign instSlots[k] = '{window: window[k], len: lens[k], cls: parcelCls[k],
                            off: offT'(k)};
    assign jumpSlots[k] = '{cls: parcelCls[k], off: offT'(k), text: window[k][31:0]};
    assign jumpSel[k]   = startMask[k] & parcelCls[k].jump; // only real starts
  end

  laneSelect #(.payloadT(instSlotT), .NUM_IN(`PD_PARCELS), .NUM_LANES(`PD_LANES))
    uInstLanes (
      .sel      (startMask),
      .payloads (instSlots),
      .lanes    (laneSlots),
      .laneEn   (laneInstEn),
      .overflow (instOverflow)
    );

  laneSelect #(.payloadT(jumpSlotT), .NUM_IN(`PD_PARCELS), .NUM_LANES(`PD_JLANES))
    uJumpLanes (
      .sel      (jumpSel),
      .payloads (jumpSlots),
      .lanes    (laneJumps),
      .laneEn   (laneJumpEn),
      .overflow (jumpOverflow)
    );

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      slots    <= '0;
      instrEn  <= '0;
      jumps    <= '0;
      jumpEn   <= '0;
      hasJumps <= 1'b0;
      error    <= 1'b0;
      jerror   <= 1'b0;
    end else begin
      for (int i = 0; i < `PD_LANES; i++)
        slots[i] <= laneSlots[i];
      for (int j = 0; j < `PD_JLANES; j++)
        jumps[j] <= laneJumps[j];
      instrEn  <= laneInstEn;
      jumpEn   <= laneJumpEn;
      hasJumps <= |jumpSel;
      error    <= instOverflow | badOff; // too many starts or offset past bundle
      jerror   <= jumpOverflow;
    end
  end

endmodule

/* src/predecode_config.svh */
// Size defines for the instruction predecoder.
// Include wherever bundle, lane or window widths are needed.

`ifndef PREDECODE_CONFIG_SVH
`define PREDECODE_CONFIG_SVH

`define PD_PARCELS     16 // parcels that may start an instruction
`define PD_TAIL        3  // trailing parcels so every window is complete
`define PD_PARCEL_BITS 16
`define PD_WINDOW_BITS 64 // up to four parcels of text

// output lanes
`define PD_LANES  8
`define PD_JLANES 2

`endif

/* verification/predecodeModel.svh */
// Reference model and stimulus builders for the predecoder testbench.
// Included inside the testbench module, after the package import.

`ifndef PREDECODE_MODEL_SVH
`define PREDECODE_MODEL_SVH

`include "predecode_config.svh"

localparam int BUNDLE_BITS = (`PD_PARCELS + `PD_TAIL) * `PD_PARCEL_BITS;

typedef struct packed {
  logic [BUNDLE_BITS-1:0] bundle;
  logic [`PD_PARCELS-1:0] ends;
  offT                    startOff;
} stimT;

typedef struct packed {
  instSlotT [`PD_LANES-1:0]  slots;
  logic [`PD_LANES-1:0]      instrEn;
  jumpSlotT [`PD_JLANES-1:0] jumps;
  logic [`PD_JLANES-1:0]     jumpEn;
  logic                      hasJumps;
  logic                      error;
  logic                      jerror;
} expectT;

logic [31:0] rngState = 32'd30713;

function automatic logic [31:0] nextRand();
  logic [31:0] x;
  x = rngState;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  rngState = x;
  return x;
endfunction

function automatic instClassT classOf(logic [31:0] text, lenT len);
  instClassT c;
  int op;
  int sub;
  int sel;
  c = '0;
  op = int'(text[7:0]);
  sub = int'(text[5:0]);
  sel = int'(text[15:13]);
  if (len == 2'd0) begin // one-parcel forms
    c.alu   = sub <= 19;
    c.shift = sub >= 21 && sub <= 31 && sub % 2 == 1;
    c.jump  = sub >= 48 && sub <= 51;
  end else if (op <= 39) begin
    c.mul   = text[2];
    c.shift = !text[2] && op >= 32 && op <= 35;
    c.alu   = !text[2] && !(op >= 32 && op <= 35);
  end else if (op <= 45) begin
    c.shift = 1'b1;
  end else if (op >= 64 && op <= 159) begin
    c.load  = op % 2 == 0;
    c.store = op % 2 == 1;
  end else if ((op >= 160 && op <= 175) || op == 178 || op == 179) begin
    c.jump = 1'b1;
    c.alu  = 1'b1;
  end else if (op == 180 || op == 181) begin
    c.jump = 1'b1;
  end else if (op == 182 && sel <= 3) begin
    c.jump  = 1'b1;
    c.indir = sel == 0 || sel == 3;
    c.store = sel == 1 || sel == 2; // calls
  end
  return c;
endfunction

function automatic expectT predict(stimT s);
  expectT e;
  instClassT c;
  logic [`PD_WINDOW_BITS-1:0] win;
  int n;
  int nj;
  int len;
  e = '0;
  n = 0;
  nj = 0;
  for (int k = 0; k < `PD_PARCELS; k++) begin
    if (k >= int'(s.startOff) && (k == 0 || s.ends[k-1])) begin
      len = 4;
      for (int d = 2; d >= 0; d--) begin
        if (k + d < `PD_PARCELS && s.ends[k+d])
          len = d + 1;
      end
      win = s.bundle[k*`PD_PARCEL_BITS +: `PD_WINDOW_BITS];
      c = classOf(win[31:0], lenT'(len - 1));
      if (n < `PD_LANES) begin
        e.slots[n].window = win;
        e.slots[n].len    = lenT'(len - 1);
        e.slots[n].cls    = c;
        e.slots[n].off    = offT'(k);
        e.instrEn[n]      = 1'b1;
      end
      n++;
      if (c.jump) begin
        if (nj < `PD_JLANES) begin
          e.jumps[nj].cls  = c;
          e.jumps[nj].off  = offT'(k);
          e.jumps[nj].text = win[31:0];
          e.jumpEn[nj]     = 1'b1;
        end
        nj++;
      end
    end
  end
  e.hasJumps = nj > 0;
  e.error    = n > `PD_LANES || int'(s.startOff) >= `PD_PARCELS;
  e.jerror   = nj > `PD_JLANES;
  return e;
endfunction

// every parcel is a one-parcel instruction, sub-opcodes spread over the groups
function automatic stimT compactBundle(int off);
  stimT s;
  logic [15:0] p;
  s = '0;
  for (int k = 0; k < `PD_PARCELS + `PD_TAIL; k++) begin
    p = 16'(nextRand());
    p[5:0] = 6'((k * 7) % 64);
    s.bundle[k*`PD_PARCEL_BITS +: `PD_PARCEL_BITS] = p;
  end
  s.ends = '1;
  s.startOff = offT'(off);
  return s;
endfunction

function automatic stimT randomBundle();
  stimT s;
  logic [31:0] r;
  int k;
  int len;
  s = '0;
  for (int i = 0; i < `PD_PARCELS + `PD_TAIL; i++)
    s.bundle[i*`PD_PARCEL_BITS +: `PD_PARCEL_BITS] = 16'(nextRand());
  k = 0;
  while (k < `PD_PARCELS) begin
    r = nextRand();
    len = int'(r[1:0]) + 1;
    if (r[4:2] == 3'd0)
      s.bundle[k*`PD_PARCEL_BITS +: 8] = 8'd182; // bits 15-13 stay random
    else if (r[4:2] == 3'd1)
      s.bundle[k*`PD_PARCEL_BITS +: 8] = 8'(160 + int'(r[12:8]) % 22);
    if (k + len - 1 < `PD_PARCELS)
      s.ends[k+len-1] = 1'b1;
    k += len;
  end
  r = nextRand();
  s.startOff = (r[1:0] == 2'd0) ? offT'(r[7:4]) : '0;
  return s;
endfunction

// eight two-parcel instructions, the first nJumps odd ones are jumps
function automatic stimT jumpBundle(int nJumps);
  stimT s;
  s = '0;
  for (int i = 0; i < `PD_PARCELS + `PD_TAIL; i++)
    s.bundle[i*`PD_PARCEL_BITS +: `PD_PARCEL_BITS] = 16'(nextRand());
  for (int i = 0; i < 8; i++)
    s.bundle[i*2*`PD_PARCEL_BITS +: 8] = 8'd0;
  for (int j = 0; j < nJumps; j++)
    s.bundle[(4*j+2)*`PD_PARCEL_BITS +: 8] = 8'(160 + 9 * j);
  s.ends = 16'hAAAA;
  return s;
endfunction

`endif

/* verification/predecodeTb.sv */
// Testbench for the predecoder top level.
// Drives fixed and random bundles and checks every output field one
// cycle later against the reference model.

`timescale 1ns/1ps

module predecodeTb import predecodePkg::*; ();

  `include "predecodeModel.svh"

  // stimulus cycles plus two idle cycles per test
  localparam int NUM_VECTORS = 2 + 2 + 400 + 4 + 3 + 6 + 6 * 2;

  logic                      clk = 1'b0;
  logic                      arstN;
  logic [BUNDLE_BITS-1:0]    bundle;
  logic [`PD_PARCELS-1:0]    ends;
  offT                       startOff;
  instSlotT [`PD_LANES-1:0]  slots;
  logic [`PD_LANES-1:0]      instrEn;
  jumpSlotT [`PD_JLANES-1:0] jumps;
  logic [`PD_JLANES-1:0]     jumpEn;
  logic                      hasJumps;
  logic                      error;
  logic                      jerror;

  stimT   cur;
  expectT expQ = '0;
  int     passCount = 0;
  int     failCount = 0;
  int     testFailBase = 0;

  always #10 clk = ~clk;

  predecodeTop u_dut (
    .clk      (clk),
    .arstN    (arstN),
    .bundle   (bundle),
    .ends     (ends),
    .startOff (startOff),
    .slots    (slots),
    .instrEn  (instrEn),
    .jumps    (jumps),
    .jumpEn   (jumpEn),
    .hasJumps (hasJumps),
    .error    (error),
    .jerror   (jerror)
  );

  task automatic applyStim(stimT s);
    bundle   <= s.bundle;
    ends     <= s.ends;
    startOff <= s.startOff;
  endtask

  task automatic checkField(string name, logic [127:0] got, logic [127:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      failCount++;
    end else begin
      passCount++;
    end
  endtask

  task automatic checkOutputs(expectT e);
    for (int i = 0; i < `PD_LANES; i++)
      checkField($sformatf("slots[%0d]", i), slots[i], e.slots[i]);
    for (int j = 0; j < `PD_JLANES; j++)
      checkField($sformatf("jumps[%0d]", j), jumps[j], e.jumps[j]);
    checkField("instrEn", instrEn, e.instrEn);
    checkField("jumpEn", jumpEn, e.jumpEn);
    checkField("hasJumps", hasJumps, e.hasJumps);
    checkField("error", error, e.error);
    checkField("jerror", jerror, e.jerror);
  endtask

  // last vector is compared at the negedge before the second posedge
  task automatic finishTest(string name);
    @(posedge clk);
    @(posedge clk);
    if (failCount == testFailBase)
      $display("%s: passed", name);
    else
      $display("%s: failed with %0d mismatches", name, failCount - testFailBase);
    testFailBase = failCount;
  endtask

  // expectation from the inputs the DUT samples at this edge
  always @(posedge clk) begin
    cur.bundle   = bundle;
    cur.ends     = ends;
    cur.startOff = startOff;
    expQ = arstN ? predict(cur) : '0;
  end

  always @(negedge clk)
    checkOutputs(expQ);

  initial begin
    stimT s;
    arstN    = 1'b0;
    bundle   = '0;
    ends     = '0;
    startOff = '0;
    @(posedge clk);
    applyStim(compactBundle(0)); // held off by reset
    @(posedge clk);
    arstN <= 1'b1;
    finishTest("reset");

    @(posedge clk);
    applyStim(compactBundle(0));
    @(posedge clk);
    applyStim(compactBundle(8));
    finishTest("compact lanes");

    repeat (400) begin
      @(posedge clk);
      applyStim(randomBundle());
    end
    finishTest("random bundles");

    for (int n = 0; n <= 3; n++) begin
      @(posedge clk);
      applyStim(jumpBundle(n));
    end
    finishTest("jump lanes");

    s = compactBundle(0);
    @(posedge clk);
    applyStim(s);
    s.startOff = offT'(16);
    @(posedge clk);
    applyStim(s);
    s.startOff = offT'(31);
    @(posedge clk);
    applyStim(s);
    finishTest("overflow and bad offset");

    @(posedge clk);
    applyStim(compactBundle(3));
    @(posedge clk);
    applyStim(jumpBundle(2));
    @(posedge clk);
    applyStim(randomBundle());
    @(posedge clk);
    applyStim(compactBundle(12));
    @(posedge clk);
    applyStim(jumpBundle(1));
    @(posedge clk);
    applyStim(randomBundle());
    finishTest("back to back");

    $display("checks: %0d passed, %0d failed", passCount, failCount);
    if (failCount == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    #(NUM_VECTORS * 20 + 2000);
    $display("Timeout: the run did not finish in the expected time");
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule
